//--- zx_ports.f
rtl/zx_ports_pkg.sv
rtl/port_decode.sv
rtl/page_7ffd.sv
rtl/xt_config_regs.sv
rtl/sd_spi_ctrl.sv
rtl/port_read_mux.sv
rtl/zx_ports.sv
+incdir+test
test/zx_ports_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the port controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module zx_ports_tb -f zx_ports.f -o zx_ports_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/zx_ports_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- test/zx_ports_ref.svh
// reference model of the port controller for register updates, lock, chip selects and read data
`ifndef ZX_PORTS_REF_SVH
`define ZX_PORTS_REF_SVH

function automatic zx_ports_pkg::sys_cfg_t cfg_reset_value();
  zx_ports_pkg::sys_cfg_t c;
  c.rampage0 = zx_ports_pkg::RST_RAMPAGE0;
  c.rampage1 = zx_ports_pkg::RST_RAMPAGE1;
  c.rampage2 = zx_ports_pkg::RST_RAMPAGE2;
  c.rampage3 = zx_ports_pkg::RST_RAMPAGE3;
  c.sysconf  = zx_ports_pkg::RST_SYSCONF;
  c.memconf  = zx_ports_pkg::RST_MEMCONF;
  c.intmask  = zx_ports_pkg::RST_INTMASK;
  return c;
endfunction

function automatic logic decodes_to_port(input logic [15:0] addr, input logic dos_l);
  case (addr[7:0])
    8'hfe, 8'haf, 8'hdf, 8'h77, 8'h57:
      return 1'b1;
    8'hfd:
      return !addr[15]; // #7FFD only with a15 low
    8'h1f:
      return !dos_l;
    default:
      return 1'b0;
  endcase
endfunction

// classic paging write that survives the 48K lock
function automatic logic paging_write_taken(input logic [15:0] addr, input logic wr_s,
                                            input logic lock);
  return wr_s && (addr[7:0] == 8'hfd) && !addr[15] && !lock;
endfunction

function automatic logic [7:0] page3_for_mode(input logic [1:0] mode, input logic [7:0] d);
  case (mode)
    2'd3:    return {2'b00, d[5], d[7:6], d[2:0]};
    2'd1:    return {5'b00000, d[2:0]};
    default: return {3'b000, d[7:6], d[2:0]}; // mode 2 acts unlocked
  endcase
endfunction

function automatic zx_ports_pkg::sys_cfg_t cfg_after_access(input zx_ports_pkg::sys_cfg_t c,
    input logic lock, input logic [15:0] addr, input logic [7:0] d, input logic wr_s);
  zx_ports_pkg::sys_cfg_t n;
  n = c;
  if (paging_write_taken(addr, wr_s, lock))
  begin
    n.rampage3   = page3_for_mode(c.memconf[7:6], d);
    n.memconf[0] = d[4];
  end
  else if (wr_s && (addr[7:0] == 8'haf))
  begin
    case (addr[15:8])
      8'h10: n.rampage0 = d;
      8'h11: n.rampage1 = d;
      8'h12: n.rampage2 = d;
      8'h13: n.rampage3 = d;
      8'h20: n.sysconf  = d;
      8'h21: n.memconf  = d;
      8'h2a: n.intmask  = d;
      default: n = c;
    endcase
  end
  return n;
endfunction

function automatic logic lock_after_access(input logic lock, input zx_ports_pkg::sys_cfg_t c,
    input logic [15:0] addr, input logic [7:0] d, input logic wr_s);
  if (paging_write_taken(addr, wr_s, lock) && (c.memconf[7:6] != 2'd3))
    return d[5];
  return lock;
endfunction

// {sdcs_n, sd2cs_n}
function automatic logic [1:0] cs_after_access(input logic [1:0] cs, input logic [15:0] addr,
                                               input logic [7:0] d, input logic wr_s);
  if (wr_s && (addr[7:0] == 8'h77))
    return {d[1], ~d[4]};
  return cs;
endfunction

function automatic logic pwr_after_access(input logic pwr, input logic [15:0] addr,
                                          input logic rd_s);
  if (rd_s && (addr == 16'h00af))
    return 1'b0;
  return pwr;
endfunction

function automatic logic [7:0] read_data_for(input logic [15:0] addr, input logic dos_l,
    input zx_ports_pkg::sys_cfg_t c, input logic pwr, input zx_ports_pkg::rd_src_t src);
  case (addr[7:0])
    8'hfe: return {1'b1, src.tape, 1'b1, src.keys};
    8'haf:
    begin
      case (addr[15:8])
        8'h00:   return {1'b0, pwr, 1'b0, 2'b00, 3'b000};
        8'h12:   return c.rampage2;
        8'h13:   return c.rampage3;
        default: return 8'hff;
      endcase
    end
    8'h1f: return dos_l ? 8'hff : {3'b000, src.kjoy};
    8'hdf: return src.mouse;
    8'h77: return 8'h00;
    8'h57: return src.sd_data;
    default: return 8'hff;
  endcase
endfunction

`endif

//--- test/zx_ports_tb.sv
// testbench for the port controller with random bus accesses checked against a reference model
`timescale 1ns/1ps

module zx_ports_tb;

  localparam int N_RANDOM    = 1500;
  localparam int TEST_CYCLES = 16 + 8 + N_RANDOM + 4 * 48 + 20;

  logic                   clk;
  logic                   rst;
  logic [15:0]            a;
  logic [7:0]             din;
  logic                   iowr_s;
  logic                   iord_s;
  logic                   iord;
  logic                   dos;
  zx_ports_pkg::rd_src_t  rd_src;
  logic [7:0]             dout;
  logic                   dataout;
  logic                   porthit;
  zx_ports_pkg::sys_cfg_t cfg;
  logic [31:0]            xt_page;
  logic                   sdcs_n;
  logic                   sd2cs_n;
  logic                   sd_start;
  logic [7:0]             sd_datain;

  logic [31:0]            lfsr;
  int                     errors;
  int                     checks;

  // model state that follows the DUT registers
  zx_ports_pkg::sys_cfg_t m_cfg;
  zx_ports_pkg::sys_cfg_t next_cfg;
  logic                   m_lock;
  logic [1:0]             m_cs;
  logic                   m_pwr;
  logic                   exp_hit;

  `include "zx_ports_ref.svh"

  zx_ports zx_ports_inst (
    .clk(clk), .rst(rst), .a(a), .din(din), .iowr_s(iowr_s), .iord_s(iord_s),
    .iord(iord), .dos(dos), .rd_src(rd_src), .dout(dout), .dataout(dataout),
    .porthit(porthit), .cfg(cfg), .xt_page(xt_page), .sdcs_n(sdcs_n),
    .sd2cs_n(sd2cs_n), .sd_start(sd_start), .sd_datain(sd_datain)
  );

  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s = %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // one bus cycle where kind 0 is idle, 1 write and 2 read
  task automatic access(input logic [15:0] addr, input logic [7:0] data, input int kind,
                        input logic dos_val);
    logic [31:0] src_bits;
    take_bits(27, src_bits);
    @(posedge clk);
    a      <= addr;
    din    <= data;
    iowr_s <= (kind == 1);
    iord_s <= (kind == 2);
    iord   <= (kind == 2);
    dos    <= dos_val;
    rd_src <= src_bits[26:0];
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst    <= 1'b1;
    iowr_s <= 1'b0;
    iord_s <= 1'b0;
    iord   <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  endtask

  function automatic logic [7:0] xt_num(input logic [2:0] idx);
    case (idx)
      3'd0:    return 8'h00;
      3'd1:    return 8'h10;
      3'd2:    return 8'h11;
      3'd3:    return 8'h12;
      3'd4:    return 8'h13;
      3'd5:    return 8'h20;
      3'd6:    return 8'h21;
      default: return 8'h2a;
    endcase
  endfunction

  task automatic random_access();
    logic [31:0] port;
    logic [31:0] hi;
    logic [31:0] data;
    logic [31:0] strobe;
    logic [31:0] dos_bit;
    logic [31:0] extra;
    logic [15:0] addr;
    take_bits(3, port);
    take_bits(8, hi);
    take_bits(8, data);
    take_bits(2, strobe);
    take_bits(1, dos_bit);
    case (port[2:0])
      3'd0: addr = {hi[7:0], 8'hfe};
      3'd1:
      begin
        take_bits(4, extra);
        addr = {(extra[3:0] == 4'hf) ? hi[7:0] : xt_num(extra[2:0]), 8'haf};
      end
      3'd2:
      begin
        take_bits(2, extra);
        if (extra[1:0] != 2'b00)
          data[5] = 1'b0; // keep the 48K lock rare
        addr = {hi[7:0], 8'hfd}; // a15 high half the time
      end
      3'd3: addr = {hi[7:0], 8'h1f};
      3'd4: addr = {hi[7:0], 8'hdf};
      3'd5: addr = {hi[7:0], 8'h77};
      3'd6: addr = {hi[7:0], 8'h57};
      default:
      begin
        take_bits(16, extra);
        addr = extra[15:0];
      end
    endcase
    access(addr, data[7:0], (strobe[1:0] == 2'd2) ? 2 : ((strobe[1:0] == 2'd0) ? 0 : 1),
           dos_bit[0]);
  endtask

  task automatic lock_mode_test(input logic [1:0] mode);
    logic [31:0] data;
    apply_reset();
    access(16'h21af, {mode, 6'b000100}, 1, 1'b0);
    repeat (6)
    begin
      take_bits(8, data);
      data[5] = 1'b0;
      access(16'h7ffd, data[7:0], 1, 1'b0);
      access(16'h13af, 8'h00, 2, 1'b0); // read back rampage3
    end
    take_bits(8, data);
    data[5] = 1'b1; // lock unless in 1M mode
    access(16'h7ffd, data[7:0], 1, 1'b0);
    access(16'h13af, 8'h00, 2, 1'b0);
    repeat (4)
    begin
      take_bits(8, data);
      access(16'h7ffd, data[7:0], 1, 1'b0);
      access(16'h13af, 8'h00, 2, 1'b0);
    end
    access(16'h0000, 8'h00, 0, 1'b0);
  endtask

  // compare at the falling edge and step the model with this cycle's strobe
  always @(negedge clk)
  begin
    if (rst)
    begin
      m_cfg  = cfg_reset_value();
      m_lock = 1'b0;
      m_cs   = 2'b11;
      m_pwr  = 1'b1;
    end
    else
    begin
      exp_hit = decodes_to_port(a, dos);
      check_val("cfg", 64'(cfg), 64'(m_cfg));
      check_val("xt_page", 64'(xt_page),
                64'({m_cfg.rampage3, m_cfg.rampage2, m_cfg.rampage1, m_cfg.rampage0}));
      check_val("sdcs_n", 64'(sdcs_n), 64'(m_cs[1]));
      check_val("sd2cs_n", 64'(sd2cs_n), 64'(m_cs[0]));
      check_val("porthit", 64'(porthit), 64'(exp_hit));
      check_val("dataout", 64'(dataout), 64'(exp_hit && iord));
      check_val("dout", 64'(dout), 64'(read_data_for(a, dos, m_cfg, m_pwr, rd_src)));
      check_val("sd_start", 64'(sd_start), 64'((a[7:0] == 8'h57) && (iowr_s || iord_s)));
      check_val("sd_datain", 64'(sd_datain), 64'((exp_hit && iowr_s) ? din : 8'hff));
      next_cfg = cfg_after_access(m_cfg, m_lock, a, din, iowr_s);
      m_lock   = lock_after_access(m_lock, m_cfg, a, din, iowr_s);
      m_cfg    = next_cfg;
      m_cs     = cs_after_access(m_cs, a, din, iowr_s);
      m_pwr    = pwr_after_access(m_pwr, a, iord_s);
    end
  end

  initial
  begin
    #(TEST_CYCLES * 10 + 1000);
    $display("timeout, run did not finish; checks: %0d, errors: %0d", checks, errors);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    clk    = 1'b0;
    rst    = 1'b1;
    a      = '0;
    din    = '0;
    iowr_s = 1'b0;
    iord_s = 1'b0;
    iord   = 1'b0;
    dos    = 1'b0;
    rd_src = '0;
    lfsr   = 32'h59b6;
    errors = 0;
    checks = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    access(16'h00af, 8'h00, 2, 1'b0); // power-up bit still 1
    access(16'h00af, 8'h00, 2, 1'b0);
    access(16'h00af, 8'h00, 2, 1'b0);
    access(16'h0000, 8'h00, 0, 1'b0);
    repeat (N_RANDOM) random_access();
    for (int m = 0; m < 4; m++)
      lock_mode_test(m[1:0]);
    access(16'h0000, 8'h00, 0, 1'b0);
    @(negedge clk);
    @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- rtl/zx_ports.sv
// port controller top, joins decode, config registers, paging, SD and read mux
`timescale 1ns/1ps

module zx_ports
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [15:0]             a,
  input  logic [7:0]              din,
  input  logic                    iowr_s,
  input  logic                    iord_s,
  input  logic                    iord,
  input  logic                    dos,
  input  zx_ports_pkg::rd_src_t   rd_src,
  output logic [7:0]              dout,
  output logic                    dataout,
  output logic                    porthit,
  output zx_ports_pkg::sys_cfg_t  cfg,
  output logic [31:0]             xt_page,
  output logic                    sdcs_n,
  output logic                    sd2cs_n,
  output logic                    sd_start,
  output logic [7:0]              sd_datain
);

  zx_ports_pkg::port_req_t  req;
  zx_ports_pkg::lock_mode_e lock_mode;
  logic                     p7ffd_wr;
  logic [7:0]               page3;
  logic                     mem_bit0;

  assign lock_mode = zx_ports_pkg::lock_mode_e'(cfg.memconf[7:6]);
  assign xt_page   = {cfg.rampage3, cfg.rampage2, cfg.rampage1, cfg.rampage0};
  assign dataout   = porthit && iord; // drive the cpu bus only on our own reads

  port_decode port_decode_inst (
    .a(a), .iowr_s(iowr_s), .iord_s(iord_s), .dos(dos),
    .req(req), .porthit(porthit)
  );

  page_7ffd page_7ffd_inst (
    .clk(clk), .rst(rst), .req(req), .din(din), .lock_mode(lock_mode),
    .p7ffd_wr(p7ffd_wr), .page3(page3), .mem_bit0(mem_bit0)
  );

  xt_config_regs xt_config_regs_inst (
    .clk(clk), .rst(rst), .req(req), .din(din),
    .p7ffd_wr(p7ffd_wr), .page3(page3), .mem_bit0(mem_bit0),
    .cfg(cfg)
  );

  sd_spi_ctrl sd_spi_ctrl_inst (
    .clk(clk), .rst(rst), .req(req), .din(din),
    .sdcs_n(sdcs_n), .sd2cs_n(sd2cs_n),
    .sd_start(sd_start), .sd_datain(sd_datain)
  );

  port_read_mux port_read_mux_inst (
    .clk(clk), .rst(rst), .req(req), .cfg(cfg), .rd_src(rd_src),
    .dout(dout)
  );

endmodule

//--- rtl/port_read_mux.sv
// read data multiplexer for the internal ports plus the power-up status flag
`timescale 1ns/1ps

module port_read_mux
(
  input  logic                     clk,
  input  logic                     rst,
  input  zx_ports_pkg::port_req_t  req,
  input  zx_ports_pkg::sys_cfg_t   cfg,
  input  zx_ports_pkg::rd_src_t    rd_src,
  output logic [7:0]               dout
);

  logic pwr_up;
  logic status_rd;

  assign status_rd = req.xt && req.rd && (req.xt_reg == zx_ports_pkg::XT_STATUS);

  // set by reset, gone after the first status read
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pwr_up <= 1'b1;
    else if (status_rd)
      pwr_up <= 1'b0;
  end

  always_comb
  begin
    dout = 8'hff; // open bus
    if (req.fe)
      dout = {1'b1, rd_src.tape, 1'b1, rd_src.keys};
    else if (req.xt)
    begin
      case (req.xt_reg)
        zx_ports_pkg::XT_STATUS:
          dout = {1'b0, pwr_up, zx_ports_pkg::FDR_VER, 2'b00, zx_ports_pkg::VDAC_VER};
        zx_ports_pkg::XT_RAMPAGE2:
          dout = cfg.rampage2;
        zx_ports_pkg::XT_RAMPAGE3:
          dout = cfg.rampage3;
        default:
          dout = 8'hff; // write-only registers
      endcase
    end
    else if (req.kjoy)
      dout = {3'b000, rd_src.kjoy};
    else if (req.kmouse)
      dout = rd_src.mouse;
    else if (req.sdcfg)
      dout = 8'h00; // card present, not write protected
    else if (req.sddat)
      dout = rd_src.sd_data;
  end

endmodule

//--- rtl/sd_spi_ctrl.sv
// SD card chip selects and SPI transfer start, Z-controller compatible
`timescale 1ns/1ps

module sd_spi_ctrl
(
  input  logic                     clk,
  input  logic                     rst,
  input  zx_ports_pkg::port_req_t  req,
  input  logic [7:0]               din,
  output logic                     sdcs_n,
  output logic                     sd2cs_n,
  output logic                     sd_start,
  output logic [7:0]               sd_datain
);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sdcs_n  <= 1'b1;
      sd2cs_n <= 1'b1;
    end
    else if (req.sdcfg && req.wr)
    begin
      sdcs_n  <= din[1];
      sd2cs_n <= ~din[4]; // second card select is active high in the port
    end
  end

  // any access to the data port kicks one byte exchange
  assign sd_start  = req.sddat && (req.wr || req.rd);
  assign sd_datain = req.wr ? din : 8'hff; // reads shift out ones
endmodule

//--- rtl/xt_config_regs.sv
// extended configuration registers written through #xxAF and #7FFD
`timescale 1ns/1ps

module xt_config_regs
(
  input  logic                     clk,
  input  logic                     rst,
  input  zx_ports_pkg::port_req_t  req,
  input  logic [7:0]               din,
  input  logic                     p7ffd_wr,
  input  logic [7:0]               page3,
  input  logic                     mem_bit0,
  output zx_ports_pkg::sys_cfg_t   cfg
);

  logic xt_wr;

  assign xt_wr = req.xt && req.wr;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cfg.rampage0 <= zx_ports_pkg::RST_RAMPAGE0;
      cfg.rampage1 <= zx_ports_pkg::RST_RAMPAGE1;
      cfg.rampage2 <= zx_ports_pkg::RST_RAMPAGE2;
      cfg.rampage3 <= zx_ports_pkg::RST_RAMPAGE3;
      cfg.sysconf  <= zx_ports_pkg::RST_SYSCONF;
      cfg.memconf  <= zx_ports_pkg::RST_MEMCONF;
      cfg.intmask  <= zx_ports_pkg::RST_INTMASK;
    end
    else if (p7ffd_wr)
    begin
      // classic paging only touches the top window and rom bit
      cfg.rampage3   <= page3;
      cfg.memconf[0] <= mem_bit0;
    end
    else if (xt_wr)
    begin
      case (req.xt_reg)
        zx_ports_pkg::XT_RAMPAGE0:
          cfg.rampage0 <= din;
        zx_ports_pkg::XT_RAMPAGE1:
          cfg.rampage1 <= din;
        zx_ports_pkg::XT_RAMPAGE2:
          cfg.rampage2 <= din;
        zx_ports_pkg::XT_RAMPAGE3:
          cfg.rampage3 <= din;
        zx_ports_pkg::XT_SYSCONF:
          cfg.sysconf <= din;
        zx_ports_pkg::XT_MEMCONF:
          cfg.memconf <= din; // lock mode lives in 7:6
        zx_ports_pkg::XT_INTMASK:
          cfg.intmask <= din;
        default:
        begin
          // status and unmapped numbers, nothing to store
        end
      endcase
    end
  end

endmodule

//--- rtl/page_7ffd.sv
// classic #7FFD paging with the 48K lock and the memconf lock modes
`timescale 1ns/1ps

module page_7ffd
(
  input  logic                     clk,
  input  logic                     rst,
  input  zx_ports_pkg::port_req_t  req,
  input  logic [7:0]               din,
  input  zx_ports_pkg::lock_mode_e lock_mode,
  output logic                     p7ffd_wr,
  output logic [7:0]               page3,
  output logic                     mem_bit0
);

  logic lock48;

  assign p7ffd_wr = req.p7ffd && req.wr && !lock48;

  always_comb
  begin
    case (lock_mode)
      zx_ports_pkg::LOCK_1M:  page3 = {2'b00, din[5], din[7:6], din[2:0]};
      zx_ports_pkg::LOCK_128: page3 = {5'b00000, din[2:0]};
      default:                page3 = {3'b000, din[7:6], din[2:0]};
    endcase
  end

  assign mem_bit0 = din[4]; // rom select

  // bit 5 locks further paging, in 1M mode it is a page bit instead
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != zx_ports_pkg::LOCK_1M))
      lock48 <= din[5];
  end

endmodule

//--- rtl/port_decode.sv
// port address decoder, turns the bus address and strobes into one request
`timescale 1ns/1ps

module port_decode
(
  input  logic [15:0]              a,
  input  logic                     iowr_s,
  input  logic                     iord_s,
  input  logic                     dos,
  output zx_ports_pkg::port_req_t  req,
  output logic                     porthit
);

  logic [7:0] loa;
  logic [7:0] hoa;
  logic       hit_fe;
  logic       hit_xt;
  logic       hit_7ffd;
  logic       hit_sdcfg;
  logic       hit_sddat;
  logic       hit_kjoy;
  logic       hit_kmouse;

  assign loa = a[7:0];
  assign hoa = a[15:8];

  assign hit_fe     = (loa == zx_ports_pkg::PORT_FE);
  assign hit_xt     = (loa == zx_ports_pkg::PORT_XT);
  assign hit_7ffd   = (loa == zx_ports_pkg::PORT_FD) && !a[15]; // a15 high is AY
  assign hit_sdcfg  = (loa == zx_ports_pkg::PORT_SDCFG);
  assign hit_sddat  = (loa == zx_ports_pkg::PORT_SDDAT);
  assign hit_kmouse = (loa == zx_ports_pkg::PORT_KMOUSE);

  // #1F belongs to the floppy controller in dos
  assign hit_kjoy   = (loa == zx_ports_pkg::PORT_KJOY) && !dos;

  assign porthit = hit_fe | hit_xt | hit_7ffd | hit_sdcfg | hit_sddat
                 | hit_kjoy | hit_kmouse;

  always_comb
  begin
    req        = '0;
    req.fe     = hit_fe;
    req.xt     = hit_xt;
    req.p7ffd  = hit_7ffd;
    req.sdcfg  = hit_sdcfg;
    req.sddat  = hit_sddat;
    req.kjoy   = hit_kjoy;
    req.kmouse = hit_kmouse;
    req.wr     = iowr_s && porthit;
    req.rd     = iord_s && porthit;
    req.xt_reg = zx_ports_pkg::xt_reg_e'(hoa); // unlisted numbers fall to defaults
  end

endmodule

//--- rtl/zx_ports_pkg.sv
// shared port addresses, register numbers, reset values and bus structs for the port controller
package zx_ports_pkg;

  // low address byte of each decoded port
  localparam logic [7:0] PORT_FE     = 8'hfe;
  localparam logic [7:0] PORT_FD     = 8'hfd; // #7FFD when a15 low
  localparam logic [7:0] PORT_XT     = 8'haf;
  localparam logic [7:0] PORT_KJOY   = 8'h1f;
  localparam logic [7:0] PORT_KMOUSE = 8'hdf;
  localparam logic [7:0] PORT_SDCFG  = 8'h77;
  localparam logic [7:0] PORT_SDDAT  = 8'h57;

  // extended register number, high byte of #xxAF
  typedef enum logic [7:0] {
    XT_STATUS   = 8'h00,
    XT_RAMPAGE0 = 8'h10,
    XT_RAMPAGE1 = 8'h11,
    XT_RAMPAGE2 = 8'h12,
    XT_RAMPAGE3 = 8'h13,
    XT_SYSCONF  = 8'h20,
    XT_MEMCONF  = 8'h21,
    XT_INTMASK  = 8'h2a
  } xt_reg_e;

  // memconf[7:6]
  typedef enum logic [1:0] {
    LOCK_NONE = 2'd0,
    LOCK_128  = 2'd1,
    LOCK_M1   = 2'd2, // no opcode snoop here, behaves as none
    LOCK_1M   = 2'd3
  } lock_mode_e;

  localparam logic [7:0] RST_RAMPAGE0 = 8'h00;
  localparam logic [7:0] RST_RAMPAGE1 = 8'h05;
  localparam logic [7:0] RST_RAMPAGE2 = 8'h02;
  localparam logic [7:0] RST_RAMPAGE3 = 8'h00;
  localparam logic [7:0] RST_SYSCONF  = 8'h00; // 3.5 MHz
  localparam logic [7:0] RST_MEMCONF  = 8'h04; // rom map off
  localparam logic [7:0] RST_INTMASK  = 8'h01; // frame int only

  localparam logic [2:0] VDAC_VER = 3'd0;
  localparam logic       FDR_VER  = 1'b0;

  // one decoded bus access
  typedef struct packed {
    logic    fe;
    logic    xt;
    logic    p7ffd;
    logic    sdcfg;
    logic    sddat;
    logic    kjoy;
    logic    kmouse;
    logic    wr;     // write strobe on a hit
    logic    rd;     // read strobe on a hit
    xt_reg_e xt_reg;
  } port_req_t;

  typedef struct packed {
    logic [7:0] rampage3;
    logic [7:0] rampage2;
    logic [7:0] rampage1;
    logic [7:0] rampage0;
    logic [7:0] sysconf;
    logic [7:0] memconf;
    logic [7:0] intmask;
  } sys_cfg_t;

  // peripheral data returned on reads
  typedef struct packed {
    logic [4:0] keys;
    logic       tape;
    logic [4:0] kjoy;
    logic [7:0] mouse;
    logic [7:0] sd_data;
  } rd_src_t;

endpackage
